//--- design/courtLeds.sv
`timescale 1ns/1ns

module courtLeds (
    input  hockeyPkg::gameState state,
    input  hockeyPkg::coord     puckX,
    input  logic                firstHalf,
    output logic                ledA,
    output logic                ledB,
    output logic [4:0]          ledX
);

    always_comb begin
        ledA = 1'b0;
        ledB = 1'b0;
        ledX = 5'b00000;
        case (state)
            hockeyPkg::idle: begin
                ledA = 1'b1;
                ledB = 1'b1;
            end
            hockeyPkg::hitA: ledA = 1'b1;
            hockeyPkg::hitB: ledB = 1'b1;
            hockeyPkg::respA: begin
                ledA = 1'b1;
                ledX = 5'b10000;
            end
            hockeyPkg::respB: begin
                ledB = 1'b1;
                ledX = 5'b00001;
            end
            hockeyPkg::sendA, hockeyPkg::sendB: ledX = 5'b10000 >> puckX;  // column 0 on the left.
            hockeyPkg::gameOver: ledX = firstHalf ? 5'b10101 : 5'b01010;
            default: ledX = 5'b11111;  // score pause and both goal states.
        endcase
    end

endmodule

//--- design/gameControl.sv
`timescale 1ns/1ns

module gameControl (
    input  logic                clk,
    input  logic                rst,
    input  logic                btnA,
    input  logic                btnB,
    input  hockeyPkg::coord     yA,
    input  hockeyPkg::coord     yB,
    input  hockeyPkg::coord     puckY,
    input  logic                arrived,
    input  logic                expired,
    input  logic                wonA,
    input  logic                wonB,
    output hockeyPkg::gameState state,
    output logic                timerRun,
    output logic                timerClear,
    output logic                serveA,
    output logic                serveB,
    output logic                stepToA,
    output logic                stepToB,
    output logic                returnA,
    output logic                returnB,
    output logic                goalA,
    output logic                goalB
);

    hockeyPkg::gameState stateNext;
    logic firstA;    // player A serves first.
    logic inFlight;  // set once the puck has left the serving column.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= hockeyPkg::idle;
            firstA <= 1'b1;
            inFlight <= 1'b0;
        end else begin
            state <= stateNext;
            if (state == hockeyPkg::idle && (btnA || btnB)) begin
                firstA <= btnA;
            end
            if (serveA || serveB) begin
                inFlight <= 1'b0;
            end else if (stepToA || stepToB) begin
                inFlight <= 1'b1;
            end
        end
    end

    always_comb begin
        stateNext = state;
        serveA = 1'b0;
        serveB = 1'b0;
        stepToA = 1'b0;
        stepToB = 1'b0;
        returnA = 1'b0;
        returnB = 1'b0;
        goalA = 1'b0;
        goalB = 1'b0;
        case (state)
            hockeyPkg::idle: begin
                if (btnA || btnB) begin
                    stateNext = hockeyPkg::showScore;
                end
            end
            hockeyPkg::showScore: begin
                if (expired) begin
                    stateNext = firstA ? hockeyPkg::hitA : hockeyPkg::hitB;
                end
            end
            hockeyPkg::hitA: begin
                if (btnA && yA <= hockeyPkg::fieldMax) begin
                    serveA = 1'b1;
                    stateNext = hockeyPkg::sendB;
                end
            end
            hockeyPkg::hitB: begin
                if (btnB && yB <= hockeyPkg::fieldMax) begin
                    serveB = 1'b1;
                    stateNext = hockeyPkg::sendA;
                end
            end
            // the serve column also reads as arrived, so wait for the first step.
            hockeyPkg::sendA: begin
                if (arrived && inFlight) begin
                    stateNext = hockeyPkg::respA;
                end else if (expired) begin
                    stepToA = 1'b1;
                end
            end
            hockeyPkg::sendB: begin
                if (arrived && inFlight) begin
                    stateNext = hockeyPkg::respB;
                end else if (expired) begin
                    stepToB = 1'b1;
                end
            end
            hockeyPkg::respA: begin
                if (btnA && yA == puckY) begin
                    returnA = 1'b1;
                    stateNext = hockeyPkg::sendB;
                end else if (expired) begin
                    goalB = 1'b1;  // a miss scores for the opponent.
                    stateNext = hockeyPkg::goalB;
                end
            end
            hockeyPkg::respB: begin
                if (btnB && yB == puckY) begin
                    returnB = 1'b1;
                    stateNext = hockeyPkg::sendA;
                end else if (expired) begin
                    goalA = 1'b1;
                    stateNext = hockeyPkg::goalA;
                end
            end
            hockeyPkg::goalA: begin
                if (expired) begin
                    stateNext = wonA ? hockeyPkg::gameOver : hockeyPkg::hitB;
                end
            end
            hockeyPkg::goalB: begin
                if (expired) begin
                    stateNext = wonB ? hockeyPkg::gameOver : hockeyPkg::hitA;
                end
            end
            hockeyPkg::gameOver: stateNext = hockeyPkg::gameOver;
            default: stateNext = hockeyPkg::idle;
        endcase
    end

    // hit states wait on the player, so the timer only runs elsewhere.
    assign timerRun = !(state inside {hockeyPkg::idle, hockeyPkg::hitA, hockeyPkg::hitB});
    assign timerClear = (stateNext != state) || (timerRun && expired);

endmodule

//--- design/hockeyPkg.sv
package hockeyPkg;

    // game states, in the order the control FSM walks through them.
    typedef enum logic [3:0] {
        idle,
        showScore,
        hitA,
        hitB,
        sendA,       // puck travelling toward player A.
        sendB,       // puck travelling toward player B.
        respA,
        respB,
        goalA,       // player A has just scored.
        goalB,
        gameOver
    } gameState;

    typedef logic [2:0] coord;     // puck column or row.
    typedef logic [1:0] yDir;      // vertical motion of the puck.
    typedef logic [1:0] score;
    typedef logic [6:0] segments;  // active low, segment a in the msb.

    localparam coord fieldMax = 3'd4;

    localparam yDir dirUp = 2'b01;
    localparam yDir dirDown = 2'b10;

    localparam segments digitCode [0:4] = '{
        7'b0000001,
        7'b1001111,
        7'b0010010,
        7'b0000110,
        7'b1001100
    };

    localparam segments letterA = 7'b0001000;
    localparam segments letterP = 7'b1100000;  // the mark for player B.
    localparam segments dash = 7'b1111110;
    localparam segments blank = 7'b1111111;

endpackage

//--- design/hockeyTop.sv
`timescale 1ns/1ns

module hockeyTop #(
    parameter int tickLimit = 100,
    parameter int winScore = 3
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               btnA,
    input  logic               btnB,
    input  hockeyPkg::yDir     dirA,
    input  hockeyPkg::yDir     dirB,
    input  hockeyPkg::coord    yA,
    input  hockeyPkg::coord    yB,
    output logic               ledA,
    output logic               ledB,
    output logic [4:0]         ledX,
    output hockeyPkg::segments ssd4,
    output hockeyPkg::segments ssd2,
    output hockeyPkg::segments ssd1,
    output hockeyPkg::segments ssd0
);

    hockeyPkg::gameState state;
    hockeyPkg::coord puckX;
    hockeyPkg::coord puckY;
    hockeyPkg::score scoreA;
    hockeyPkg::score scoreB;
    logic timerRun;
    logic timerClear;
    logic expired;
    logic firstHalf;
    logic serveA;
    logic serveB;
    logic stepToA;
    logic stepToB;
    logic returnA;
    logic returnB;
    logic goalA;
    logic goalB;
    logic arrived;
    logic wonA;
    logic wonB;

    gameControl control0 (
        .clk(clk), .rst(rst), .btnA(btnA), .btnB(btnB), .yA(yA), .yB(yB),
        .puckY(puckY), .arrived(arrived), .expired(expired), .wonA(wonA), .wonB(wonB),
        .state(state), .timerRun(timerRun), .timerClear(timerClear),
        .serveA(serveA), .serveB(serveB), .stepToA(stepToA), .stepToB(stepToB),
        .returnA(returnA), .returnB(returnB), .goalA(goalA), .goalB(goalB)
    );

    stepTimer #(.tickLimit(tickLimit)) timer0 (
        .clk(clk), .rst(rst), .timerRun(timerRun), .timerClear(timerClear),
        .expired(expired), .firstHalf(firstHalf)
    );

    puckTracker puck0 (
        .clk(clk), .rst(rst), .dirA(dirA), .dirB(dirB), .yA(yA), .yB(yB),
        .serveA(serveA), .serveB(serveB), .stepToA(stepToA), .stepToB(stepToB),
        .returnA(returnA), .returnB(returnB),
        .puckX(puckX), .puckY(puckY), .arrived(arrived)
    );

    scoreKeeper #(.winScore(winScore)) score0 (
        .clk(clk), .rst(rst), .goalA(goalA), .goalB(goalB),
        .scoreA(scoreA), .scoreB(scoreB), .wonA(wonA), .wonB(wonB)
    );

    courtLeds leds0 (
        .state(state), .puckX(puckX), .firstHalf(firstHalf),
        .ledA(ledA), .ledB(ledB), .ledX(ledX)
    );

    scoreboardSegments segs0 (
        .state(state), .scoreA(scoreA), .scoreB(scoreB), .wonA(wonA), .wonB(wonB),
        .yA(yA), .yB(yB), .puckY(puckY),
        .ssd4(ssd4), .ssd2(ssd2), .ssd1(ssd1), .ssd0(ssd0)
    );

endmodule

//--- design/puckTracker.sv
`timescale 1ns/1ns

module puckTracker (
    input  logic            clk,
    input  logic            rst,
    input  hockeyPkg::yDir  dirA,
    input  hockeyPkg::yDir  dirB,
    input  hockeyPkg::coord yA,
    input  hockeyPkg::coord yB,
    input  logic            serveA,
    input  logic            serveB,
    input  logic            stepToA,
    input  logic            stepToB,
    input  logic            returnA,
    input  logic            returnB,
    output hockeyPkg::coord puckX,
    output hockeyPkg::coord puckY,
    output logic            arrived
);

    hockeyPkg::yDir puckDir;

    // one vertical step with bounce at the field edges.
    // On a return the code 11 counts as down, in travel it goes straight.
    function automatic logic [4:0] moveRow(hockeyPkg::coord row, hockeyPkg::yDir dir,
                                           logic onReturn);
        logic goUp;
        logic goDown;
        goUp = (dir == hockeyPkg::dirUp);
        goDown = (dir == hockeyPkg::dirDown) || (onReturn && dir == 2'b11);
        if (goUp && row == hockeyPkg::fieldMax) begin
            return {hockeyPkg::dirDown, row - 3'd1};
        end else if (goUp) begin
            return {dir, row + 3'd1};
        end else if (goDown && row == 3'd0) begin
            return {hockeyPkg::dirUp, row + 3'd1};
        end else if (goDown) begin
            return {dir, row - 3'd1};
        end
        return {dir, row};
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            puckX <= '0;
            puckY <= '0;
            puckDir <= '0;
        end else if (serveA) begin
            puckX <= '0;
            puckY <= yA;
            puckDir <= dirA;
        end else if (serveB) begin
            puckX <= hockeyPkg::fieldMax;
            puckY <= yB;
            puckDir <= dirB;
        end else if (returnA) begin
            puckX <= 3'd1;
            {puckDir, puckY} <= moveRow(puckY, dirA, 1'b1);
        end else if (returnB) begin
            puckX <= hockeyPkg::fieldMax - 3'd1;
            {puckDir, puckY} <= moveRow(puckY, dirB, 1'b1);
        end else if (stepToA || stepToB) begin
            puckX <= stepToB ? puckX + 3'd1 : puckX - 3'd1;
            {puckDir, puckY} <= moveRow(puckY, puckDir, 1'b0);
        end
    end

    assign arrived = (puckX == 3'd0) || (puckX == hockeyPkg::fieldMax);

endmodule

//--- design/scoreKeeper.sv
`timescale 1ns/1ns

module scoreKeeper #(
    parameter int winScore = 3
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            goalA,
    input  logic            goalB,
    output hockeyPkg::score scoreA,
    output hockeyPkg::score scoreB,
    output logic            wonA,
    output logic            wonB
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scoreA <= '0;
            scoreB <= '0;
        end else begin
            if (goalA) begin
                scoreA <= scoreA + 2'd1;
            end
            if (goalB) begin
                scoreB <= scoreB + 2'd1;
            end
        end
    end

    // the game stops at the winning score, so the counters never wrap.
    assign wonA = (scoreA == 2'(winScore));
    assign wonB = (scoreB == 2'(winScore));

endmodule

//--- design/scoreboardSegments.sv
`timescale 1ns/1ns

module scoreboardSegments (
    input  hockeyPkg::gameState state,
    input  hockeyPkg::score     scoreA,
    input  hockeyPkg::score     scoreB,
    input  logic                wonA,
    input  logic                wonB,
    input  hockeyPkg::coord     yA,
    input  hockeyPkg::coord     yB,
    input  hockeyPkg::coord     puckY,
    output hockeyPkg::segments  ssd4,
    output hockeyPkg::segments  ssd2,
    output hockeyPkg::segments  ssd1,
    output hockeyPkg::segments  ssd0
);

    // rows outside the field show a dash.
    function automatic hockeyPkg::segments rowCode(hockeyPkg::coord row);
        if (row <= hockeyPkg::fieldMax) begin
            return hockeyPkg::digitCode[row];
        end
        return hockeyPkg::dash;
    endfunction

    always_comb begin
        ssd4 = hockeyPkg::blank;
        ssd2 = hockeyPkg::blank;
        ssd1 = hockeyPkg::blank;
        ssd0 = hockeyPkg::blank;
        case (state)
            hockeyPkg::idle: begin
                ssd2 = hockeyPkg::letterA;
                ssd1 = hockeyPkg::dash;
                ssd0 = hockeyPkg::letterP;
            end
            hockeyPkg::showScore, hockeyPkg::goalA, hockeyPkg::goalB,
            hockeyPkg::gameOver: begin
                ssd2 = hockeyPkg::digitCode[scoreA];
                ssd1 = hockeyPkg::dash;
                ssd0 = hockeyPkg::digitCode[scoreB];
                if (state == hockeyPkg::gameOver && wonA) begin
                    ssd4 = hockeyPkg::letterA;  // winner's mark.
                end else if (state == hockeyPkg::gameOver && wonB) begin
                    ssd4 = hockeyPkg::letterP;
                end
            end
            hockeyPkg::hitA: ssd4 = rowCode(yA);
            hockeyPkg::hitB: ssd4 = rowCode(yB);
            default: ssd4 = rowCode(puckY);  // travel and the return window.
        endcase
    end

endmodule

//--- design/stepTimer.sv
`timescale 1ns/1ns

module stepTimer #(
    parameter int tickLimit = 100
) (
    input  logic clk,
    input  logic rst,
    input  logic timerRun,
    input  logic timerClear,
    output logic expired,
    output logic firstHalf
);

    localparam int countW = (tickLimit > 0) ? $clog2(tickLimit + 1) : 1;

    logic [countW-1:0] count;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (timerClear) begin
            count <= '0;
        end else if (timerRun && !expired) begin
            count <= count + 1'b1;  // holds at the limit until cleared.
        end
    end

    assign expired = (count == countW'(tickLimit));
    // rounding up keeps the two blink phases even for small limits.
    assign firstHalf = (count < countW'((tickLimit + 1) / 2));

endmodule

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; the exit status is the result.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tbHockey -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/VtbHockey
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0

//--- sources.f
+incdir+test
design/hockeyPkg.sv
design/gameControl.sv
design/stepTimer.sv
design/puckTracker.sv
design/scoreKeeper.sv
design/courtLeds.sv
design/scoreboardSegments.sv
design/hockeyTop.sv
test/hockeyTop_asserts.sv
test/tbHockey.sv

//--- test/hockeyTop_asserts.sv
`timescale 1ns/1ns

module hockeyAsserts (
    input logic                clk,
    input logic                rst,
    input logic [4:0]          ledX,
    input hockeyPkg::segments  ssd4,
    input hockeyPkg::gameState state,
    input hockeyPkg::score     scoreA,
    input hockeyPkg::score     scoreB
);

    // the court shows one column or a full-width pattern.
    ledPattern: assert property (@(posedge clk) disable iff (rst)
        $onehot0(ledX) || ledX inside {5'b11111, 5'b10101, 5'b01010})
        else $error("ledX shows the pattern %b", ledX);

    scoreDigitBlank: assert property (@(posedge clk) disable iff (rst)
        state inside {hockeyPkg::showScore, hockeyPkg::goalA, hockeyPkg::goalB}
        |-> ssd4 == hockeyPkg::blank)
        else $error("ssd4 is not blank while the score is shown");

    scoresRise: assert property (@(posedge clk) disable iff (rst)
        scoreA >= $past(scoreA) && scoreB >= $past(scoreB))
        else $error("a score went down");

endmodule

bind hockeyTop hockeyAsserts asserts0 (
    .clk(clk), .rst(rst), .ledX(ledX), .ssd4(ssd4),
    .state(state), .scoreA(scoreA), .scoreB(scoreB)
);

//--- test/hockeyTests.svh
// model of one vertical step; the code 11 counts as down only on a return.
task automatic advanceRow(input logic onReturn);
    hockeyPkg::yDir moveDir;
    moveDir = (onReturn && predDir == 2'b11) ? 2'b10 : predDir;
    case (moveDir)
        2'b01: begin
            if (predRow == 3'd4) begin
                predDir = 2'b10;  // bounce off the top edge.
                predRow = 3'd3;
            end else begin
                predRow = predRow + 3'd1;
            end
        end
        2'b10: begin
            if (predRow == 3'd0) begin
                predDir = 2'b01;
                predRow = 3'd1;
            end else begin
                predRow = predRow - 3'd1;
            end
        end
        default: predRow = predRow;  // straight.
    endcase
endtask

task automatic pressButton(input logic forA);
    @(posedge clk);
    if (forA) begin
        btnA <= 1'b1;
    end else begin
        btnB <= 1'b1;
    end
    @(posedge clk);
    btnA <= 1'b0;
    btnB <= 1'b0;
endtask

task automatic checkScores(input int a, input int b);
    checkValue("ssd2", 8'(ssd2), 8'(hockeyPkg::digitCode[3'(a)]));
    checkValue("ssd1", 8'(ssd1), 8'(hockeyPkg::dash));
    checkValue("ssd0", 8'(ssd0), 8'(hockeyPkg::digitCode[3'(b)]));
endtask

task automatic checkRow();
    checkValue("ssd4", 8'(ssd4), 8'(hockeyPkg::digitCode[predRow]));
endtask

task automatic checkResetState();
    @(negedge clk);
    checkValue("ledA", 8'(ledA), 8'd1);
    checkValue("ledB", 8'(ledB), 8'd1);
    checkValue("ledX", 8'(ledX), 8'd0);
    checkValue("ssd4", 8'(ssd4), 8'(hockeyPkg::blank));
    checkValue("ssd2", 8'(ssd2), 8'(hockeyPkg::letterA));
    checkValue("ssd1", 8'(ssd1), 8'(hockeyPkg::dash));
    checkValue("ssd0", 8'(ssd0), 8'(hockeyPkg::letterP));
endtask

task automatic startGame();
    pressButton(1'b1);
    waitLeds(1'b0, 1'b0, 5'b11111, "score display");
    checkScores(0, 0);
    waitLeds(1'b1, 1'b0, 5'b00000, "serve wait of player A");
    checkValue("ssd4", 8'(ssd4), 8'(hockeyPkg::digitCode[yA]));
endtask

// A serves from a random row; the puck crosses all five columns.
task automatic serveAndTravel();
    logic [7:0] bits;
    takeBits(3, bits);
    predRow = 3'(bits % 8'd5);
    takeBits(2, bits);
    predDir = bits[1:0];
    @(posedge clk);
    yA <= predRow;
    dirA <= predDir;
    @(negedge clk);
    checkValue("ledA", 8'(ledA), 8'd1);
    checkRow();
    pressButton(1'b1);
    waitLeds(1'b0, 1'b0, 5'b10000, "served puck at column 0");
    checkRow();
    for (int col = 1; col <= 4; col++) begin
        advanceRow(1'b0);
        waitLeds(1'b0, 1'b0, 5'b10000 >> col, "puck travelling toward B");
        checkRow();
    end
    waitLeds(1'b0, 1'b1, 5'b00001, "return window of player B");
endtask

task automatic returnFromB();
    logic [7:0] bits;
    takeBits(2, bits);
    @(posedge clk);
    yB <= predRow;  // paddle on the puck row.
    dirB <= bits[1:0];
    btnB <= 1'b1;
    @(posedge clk);
    btnB <= 1'b0;
    predDir = bits[1:0];
    advanceRow(1'b1);
    waitLeds(1'b0, 1'b0, 5'b00010, "returned puck at column 3");
    checkRow();
    for (int col = 2; col >= 0; col--) begin
        advanceRow(1'b0);
        waitLeds(1'b0, 1'b0, 5'b10000 >> col, "puck travelling toward A");
        checkRow();
    end
endtask

// A stays idle, so the window closes and B scores.
task automatic missByA();
    waitLeds(1'b0, 1'b0, 5'b11111, "goal display for B");
    expScoreB++;
    checkScores(0, expScoreB);
    checkValue("ssd4", 8'(ssd4), 8'(hockeyPkg::blank));
    if (expScoreB < winScore) begin
        waitLeds(1'b1, 1'b0, 5'b00000, "serve wait of player A after the goal");
    end
endtask

task automatic rejectServe();
    logic [7:0] bits;
    takeBits(2, bits);
    @(posedge clk);
    yA <= 3'd5 + 3'(bits % 8'd3);  // below the field.
    pressButton(1'b1);
    repeat (2 * tickCycles) begin
        @(negedge clk);
        checkValue("ledX", 8'(ledX), 8'd0);
        checkValue("ledA", 8'(ledA), 8'd1);
        checkValue("ssd4", 8'(ssd4), 8'(hockeyPkg::dash));
    end
endtask

task automatic gameOverTest();
    logic [4:0] expX;
    while (expScoreB < winScore) begin
        serveAndTravel();
        returnFromB();
        missByA();
    end
    waitLeds(1'b0, 1'b0, 5'b10101, "first blink phase");
    checkValue("ssd4", 8'(ssd4), 8'(hockeyPkg::letterP));
    checkScores(0, winScore);
    // each tick shows 10101 while the count is below half the limit, then 01010.
    for (int i = 1; i < 3 * tickCycles; i++) begin
        @(negedge clk);
        expX = ((i % tickCycles) * 2 < tickLimit) ? 5'b10101 : 5'b01010;
        checkValue("ledX", 8'(ledX), 8'(expX));
    end
endtask

//--- test/tbHockey.sv
`timescale 1ns/1ns

module tbHockey;

    localparam int tickLimit = 3;
    localparam int winScore = 3;
    localparam int tickCycles = tickLimit + 1;
    localparam int waitLimit = 3 * tickCycles;  // longest gap between two LED patterns.
    localparam int startTicks = 2;
    localparam int roundTicks = 12;  // two crossings, the return window and the goal pause.
    localparam int rejectTicks = 3;
    localparam int blinkTicks = 3;
    localparam int testTicks = startTicks + winScore * roundTicks + rejectTicks + blinkTicks;
    localparam int watchdogNs = (testTicks * tickCycles + 100) * 20;

    logic clk = 1'b0;
    logic rst;
    logic btnA;
    logic btnB;
    hockeyPkg::yDir dirA;
    hockeyPkg::yDir dirB;
    hockeyPkg::coord yA;
    hockeyPkg::coord yB;
    logic ledA;
    logic ledB;
    logic [4:0] ledX;
    hockeyPkg::segments ssd4;
    hockeyPkg::segments ssd2;
    hockeyPkg::segments ssd1;
    hockeyPkg::segments ssd0;

    logic [15:0] lfsr;
    hockeyPkg::coord predRow;   // row the puck should be on.
    hockeyPkg::yDir predDir;
    int expScoreB;

    hockeyTop #(
        .tickLimit(tickLimit),
        .winScore(winScore)
    ) dut0 (
        .clk(clk), .rst(rst), .btnA(btnA), .btnB(btnB),
        .dirA(dirA), .dirB(dirB), .yA(yA), .yB(yB),
        .ledA(ledA), .ledB(ledB), .ledX(ledX),
        .ssd4(ssd4), .ssd2(ssd2), .ssd1(ssd1), .ssd0(ssd0)
    );

    always #10 clk = ~clk;

    // galois form of x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsrNext(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic takeBits(input int n, output logic [7:0] bits);
        bits = 8'd0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            bits = {bits[6:0], lfsr[0]};  // one step per bit.
        end
    endtask

    task automatic checkValue(input string name, input logic [7:0] actual,
                              input logic [7:0] expected);
        if (actual !== expected) begin
            $display("error at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // samples on falling edges until the LEDs show the wanted pattern.
    task automatic waitLeds(input logic a, input logic b, input logic [4:0] x,
                            input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!(ledA == a && ledB == b && ledX == x) && n < waitLimit) begin
            @(negedge clk);
            n++;
        end
        if (!(ledA == a && ledB == b && ledX == x)) begin
            $display("timed out at %0t ns waiting for the %s", $time, what);
            $display("TEST FAIL");
            $fatal(1, "wait timeout");
        end
    endtask

    `include "hockeyTests.svh"

    initial begin
        #(watchdogNs);
        $display("the run took longer than %0d ns and was stopped", watchdogNs);
        $display("TEST FAIL");
        $fatal(1, "watchdog");
    end

    initial begin
        rst = 1'b1;
        btnA = 1'b0;
        btnB = 1'b0;
        dirA = 2'b00;
        dirB = 2'b00;
        yA = 3'd0;
        yB = 3'd0;
        lfsr = 16'd9723;
        predRow = 3'd0;
        predDir = 2'b00;
        expScoreB = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        checkResetState();
        startGame();
        serveAndTravel();
        returnFromB();
        missByA();
        rejectServe();
        gameOverTest();

        $display("TEST PASS");
        $finish;
    end

endmodule
